//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
verilog/pkg_cache.sv
verilog/cache_way.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/cache.sv
test/cache_properties.sv
test/cache_tb.sv

//--- test/cache_properties.sv
module cache_properties (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    int unsigned fail_count = 0;

    // The memory port carries one transfer at a time
    a_pmem_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(pmem_read && pmem_write)
    ) else begin
        fail_count++;
        $error("pmem_read and pmem_write are high together");
    end

    a_resp_with_request: assert property (
        @(posedge clk) disable iff (rst) mem_resp |-> (mem_read || mem_write)
    ) else begin
        fail_count++;
        $error("mem_resp is high without a request");
    end

    a_read_held: assert property (
        @(posedge clk) disable iff (rst) (pmem_read && !pmem_resp) |=> pmem_read
    ) else begin
        fail_count++;
        $error("pmem_read dropped before pmem_resp");
    end

    a_write_held: assert property (
        @(posedge clk) disable iff (rst) (pmem_write && !pmem_resp) |=> pmem_write
    ) else begin
        fail_count++;
        $error("pmem_write dropped before pmem_resp");
    end

    // Covers every reset cycle after the first edge and the cycle after reset
    a_quiet_after_reset: assert property (
        @(posedge clk) $past(rst) |-> !(mem_resp || pmem_read || pmem_write)
    ) else begin
        fail_count++;
        $error("response or memory strobe during or right after reset");
    end

endmodule

bind cache cache_properties u_props (
    .clk(clk),
    .rst(rst),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_resp(mem_resp),
    .pmem_read(pmem_read),
    .pmem_write(pmem_write),
    .pmem_resp(pmem_resp)
);

//--- test/cache_tb.sv
module cache_tb;

    localparam int S_INDEX      = 3;
    localparam int NUM_LINES    = 64;
    localparam int NUM_REQUESTS = 217;
    localparam int CYCLE_LIMIT  = 40 * NUM_REQUESTS;

    logic                         clk;
    logic                         rst;
    logic                         mem_read;
    logic                         mem_write;
    logic [pkg_cache::ADDR_W-1:0] mem_address;
    logic [pkg_cache::WORD_W-1:0] mem_wdata;
    logic [pkg_cache::WORD_W-1:0] mem_rdata;
    logic                         mem_resp;
    logic                         pmem_read;
    logic                         pmem_write;
    logic [pkg_cache::ADDR_W-1:0] pmem_address;
    logic [pkg_cache::LINE_W-1:0] pmem_wdata;
    logic [pkg_cache::LINE_W-1:0] pmem_rdata = '0;
    logic                         pmem_resp = 1'b0;

    pkg_cache::cache_line_u mem_lines [NUM_LINES];
    logic [31:0]            shadow [NUM_LINES*8];
    logic [31:0]            last_rd_addr;
    logic [31:0]            last_wb_addr;
    int stim_seed    = 66;
    int mem_seed     = 66;
    int errors       = 0;
    int model_errors = 0;
    int failed_tests = 0;
    int rd_count     = 0;
    int wb_count     = 0;
    int cycle        = 0;

    cache #(
        .S_INDEX(S_INDEX)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_resp(mem_resp),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata),
        .pmem_rdata(pmem_rdata),
        .pmem_resp(pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] addr_of(input int line, input int word);
        return 32'(line * 32 + word * 4);
    endfunction

    // The odd multiplier gives every address its own word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h3C5A_0F96;
    endfunction

    function automatic logic [255:0] shadow_line(input int idx);
        pkg_cache::cache_line_u l;
        for (int w = 0; w < 8; w++)
            l.words[w] = shadow[idx*8 + w];
        return l.line;
    endfunction

    function automatic int total_errors();
        return errors + model_errors;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    // Memory answers 1 to 4 cycles after a strobe and checks write-backs
    initial begin : memory_model
        int wait_cnt;
        int delay;
        int idx;
        wait_cnt = 0;
        delay = 1;
        for (int i = 0; i < NUM_LINES; i++)
            for (int w = 0; w < 8; w++)
                mem_lines[i].words[w] = fill_word(addr_of(i, w));
        forever begin
            @(negedge clk);
            if (rst || pmem_resp) begin
                pmem_resp = 1'b0;
                wait_cnt = 0;
            end else if (pmem_read || pmem_write) begin
                if (wait_cnt == 0)
                    delay = 1 + int'($unsigned($random(mem_seed)) % 4);
                wait_cnt++;
                if (wait_cnt >= delay) begin
                    idx = int'(pmem_address[10:5]);
                    assert (pmem_address[4:0] == 5'd0 && pmem_address[31:11] == '0) else begin
                        $display("Error: pmem_address %h is not a line inside memory",
                                 pmem_address);
                        model_errors++;
                    end
                    if (pmem_write) begin
                        wb_count++;
                        last_wb_addr = pmem_address;
                        assert (pmem_wdata === shadow_line(idx)) else begin
                            $display("Mismatch pmem_wdata: got %h, expected %h",
                                     pmem_wdata, shadow_line(idx));
                            model_errors++;
                        end
                        mem_lines[idx].line = pmem_wdata;
                    end else begin
                        rd_count++;
                        last_rd_addr = pmem_address;
                        pmem_rdata = mem_lines[idx].line;
                    end
                    pmem_resp = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (cycle >= CYCLE_LIMIT) begin
                $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
                $display("Some tests failed");
                $finish;
            end
        end
    end

    // Starts and ends on a falling edge and drops the request in the cycle after mem_resp
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int latency, output int strobes);
        mem_read = !wr;
        mem_write = wr;
        mem_address = addr;
        mem_wdata = wdata;
        latency = 0;
        strobes = 0;
        do begin
            @(posedge clk);
            latency++;
            if (pmem_read || pmem_write)
                strobes++;
        end while (!mem_resp);
        rdata = mem_rdata;
        @(negedge clk);
        mem_read = 1'b0;
        mem_write = 1'b0;
        @(negedge clk);
        if (wr)
            shadow[addr[10:2]] = wdata;
    endtask

    task automatic read_check(input logic [31:0] addr, output int latency, output int strobes);
        logic [31:0] rdata;
        access(1'b0, addr, '0, rdata, latency, strobes);
        compare_word($sformatf("mem_rdata at %h", addr), rdata, shadow[addr[10:2]]);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (total_errors() == errors_before) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s", name);
            failed_tests++;
        end
    endtask

    initial begin
        int          lat;
        int          strb;
        int          rd0;
        int          wb0;
        int          e0;
        logic [31:0] rdata;
        logic        wr;
        logic [31:0] addr;

        rst = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        for (int i = 0; i < NUM_LINES * 8; i++)
            shadow[i] = fill_word(32'(i * 4));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = total_errors();
        @(posedge clk);
        compare_word("mem_resp", 32'(mem_resp), 32'h0);
        compare_word("pmem_read", 32'(pmem_read), 32'h0);
        compare_word("pmem_write", 32'(pmem_write), 32'h0);
        @(negedge clk);
        report_test("outputs idle after reset", e0);

        e0 = total_errors();
        rd0 = rd_count;
        read_check(addr_of(2, 3), lat, strb);
        compare_word("pmem_read count", 32'(rd_count - rd0), 32'd1);
        compare_word("pmem_address", last_rd_addr, addr_of(2, 0));
        // The request is seen at the first rising edge and answered at the second
        read_check(addr_of(2, 5), lat, strb);
        compare_word("hit latency", 32'(lat), 32'd2);
        compare_word("pmem strobe cycles", 32'(strb), 32'd0);
        report_test("read miss then hit in the same line", e0);

        e0 = total_errors();
        access(1'b1, addr_of(3, 1), 32'hDEAD_BEEF, rdata, lat, strb);
        read_check(addr_of(3, 1), lat, strb);
        read_check(addr_of(3, 0), lat, strb);
        read_check(addr_of(3, 7), lat, strb);
        report_test("write then read of one word", e0);

        e0 = total_errors();
        read_check(addr_of(1, 0), lat, strb);
        read_check(addr_of(9, 0), lat, strb);
        read_check(addr_of(1, 1), lat, strb);
        compare_word("pmem strobe cycles", 32'(strb), 32'd0);
        rd0 = rd_count;
        read_check(addr_of(17, 2), lat, strb);
        compare_word("pmem_read count", 32'(rd_count - rd0), 32'd1);
        read_check(addr_of(1, 2), lat, strb);
        compare_word("pmem strobe cycles", 32'(strb), 32'd0);
        rd0 = rd_count;
        read_check(addr_of(9, 4), lat, strb);
        compare_word("pmem_read count", 32'(rd_count - rd0), 32'd1);
        report_test("LRU replacement in one set", e0);

        e0 = total_errors();
        wb0 = wb_count;
        access(1'b1, addr_of(4, 6), 32'h1234_5678, rdata, lat, strb);
        read_check(addr_of(12, 0), lat, strb);
        read_check(addr_of(20, 0), lat, strb);
        compare_word("write-back count", 32'(wb_count - wb0), 32'd1);
        compare_word("write-back address", last_wb_addr, addr_of(4, 0));
        wb0 = wb_count;
        read_check(addr_of(28, 0), lat, strb);
        read_check(addr_of(4, 6), lat, strb);
        compare_word("write-back count", 32'(wb_count - wb0), 32'd0);
        report_test("dirty and clean eviction", e0);

        e0 = total_errors();
        for (int i = 0; i < 200; i++) begin
            wr = 1'($random(stim_seed));
            addr = addr_of(int'($unsigned($random(stim_seed)) % 32),
                           int'($unsigned($random(stim_seed)) % 8));
            if (wr)
                access(1'b1, addr, $random(stim_seed), rdata, lat, strb);
            else
                read_check(addr, lat, strb);
        end
        expect_true(u_dut.u_props.fail_count == 0, "concurrent assertions failed during the run");
        report_test("random reads and writes", e0);

        $display("Tests: 6 run, %0d failed, %0d check errors, %0d assertion failures",
                 failed_tests, total_errors(), u_dut.u_props.fail_count);
        if (failed_tests == 0 && total_errors() == 0 && u_dut.u_props.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/cache.sv
module cache #(
    parameter int S_INDEX = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [pkg_cache::ADDR_W-1:0]  mem_address,
    input  logic [pkg_cache::WORD_W-1:0]  mem_wdata,
    output logic [pkg_cache::WORD_W-1:0]  mem_rdata,
    output logic                          mem_resp,
    output logic                          pmem_read,
    output logic                          pmem_write,
    output logic [pkg_cache::ADDR_W-1:0]  pmem_address,
    output logic [pkg_cache::LINE_W-1:0]  pmem_wdata,
    input  logic [pkg_cache::LINE_W-1:0]  pmem_rdata,
    input  logic                          pmem_resp
);

    pkg_cache::cache_ctrl_t ctrl;
    pkg_cache::cache_stat_t stat;

    cache_control u_control (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .pmem_resp(pmem_resp),
        .stat(stat),
        .mem_resp(mem_resp),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .ctrl(ctrl)
    );

    cache_datapath #(
        .S_INDEX(S_INDEX)
    ) u_datapath (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .ctrl(ctrl),
        .stat(stat),
        .pmem_rdata(pmem_rdata),
        .pmem_wdata(pmem_wdata),
        .pmem_address(pmem_address)
    );

endmodule

//--- verilog/cache_control.sv
module cache_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic                   pmem_resp,
    input  pkg_cache::cache_stat_t stat,
    output logic                   mem_resp,
    output logic                   pmem_read,
    output logic                   pmem_write,
    output pkg_cache::cache_ctrl_t ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        CMP,
        MISS,
        EVICT
    } state_t;

    state_t state;
    state_t next_state;

    function void set_defaults();
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        ctrl.ld_valid   = 1'b0;
        ctrl.ld_dirty   = 1'b0;
        ctrl.ld_tag     = 1'b0;
        ctrl.ld_data    = 1'b0;
        ctrl.ld_tmptag  = 1'b0;
        ctrl.ld_tmpdata = 1'b0;
        ctrl.ld_plru    = 1'b0;
        ctrl.dirtyval   = 1'b0;
        ctrl.dirtywmux  = pkg_cache::T_HIT;
        ctrl.datawmux   = pkg_cache::W_HIT;
        ctrl.plruwmux   = pkg_cache::U_HIT;
        ctrl.datamux    = pkg_cache::D_CPU;
        ctrl.merdmux    = pkg_cache::M_CACHE;
        ctrl.pmadmux    = pkg_cache::P_CPU;
    endfunction

    function void load_valid();
        ctrl.ld_valid = 1'b1;
    endfunction

    function void load_tag();
        ctrl.ld_tag = 1'b1;
    endfunction

    function void load_dirty(pkg_cache::dirtywmux_t sel, logic value);
        ctrl.ld_dirty  = 1'b1;
        ctrl.dirtyval  = value;
        ctrl.dirtywmux = sel;
    endfunction

    function void load_data(pkg_cache::datawmux_t sel, pkg_cache::datamux_t src);
        ctrl.ld_data  = 1'b1;
        ctrl.datawmux = sel;
        ctrl.datamux  = src;
    endfunction

    function void load_plru(pkg_cache::plruwmux_t sel);
        ctrl.ld_plru  = 1'b1;
        ctrl.plruwmux = sel;
    endfunction

    function void store_tmps();
        ctrl.ld_tmptag  = 1'b1;
        ctrl.ld_tmpdata = 1'b1;
    endfunction

    function void set_mem_rdata_mux(pkg_cache::merdmux_t sel);
        ctrl.merdmux = sel;
    endfunction

    function void set_pmem_addr_mux(pkg_cache::pmadmux_t sel);
        ctrl.pmadmux = sel;
    endfunction

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        mem_resp   = 1'b0;
        case (state)
            IDLE: begin
                if (mem_read || mem_write)
                    next_state = CMP;
            end
            CMP: begin
                if (stat.hit) begin
                    next_state = IDLE;
                    mem_resp   = 1'b1;
                end else begin
                    next_state = MISS;
                end
            end
            MISS: begin
                // A clean victim needs no write-back, so the fill ends the miss
                if (pmem_resp) begin
                    if (stat.dirty) begin
                        next_state = EVICT;
                    end else begin
                        next_state = IDLE;
                        mem_resp   = 1'b1;
                    end
                end
            end
            EVICT: begin
                if (pmem_resp) begin
                    next_state = IDLE;
                    mem_resp   = 1'b1;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        set_defaults();
        case (state)
            CMP: begin
                if (stat.hit) begin
                    if (mem_write) begin
                        load_data(pkg_cache::W_HIT, pkg_cache::D_CPU);
                        load_dirty(pkg_cache::T_HIT, 1'b1);
                    end else begin
                        set_mem_rdata_mux(pkg_cache::M_CACHE);
                    end
                    load_plru(pkg_cache::U_HIT);
                end
            end
            MISS: begin
                set_pmem_addr_mux(pkg_cache::P_CPU);
                set_mem_rdata_mux(pkg_cache::M_LLC);
                pmem_read = 1'b1;
                if (stat.dirty)
                    store_tmps();
                // The victim is latched at the same edge that installs the fill
                if (pmem_resp) begin
                    load_tag();
                    load_valid();
                    load_data(pkg_cache::W_LRU, pkg_cache::D_LLC);
                    load_dirty(pkg_cache::T_LRU, mem_write);
                    load_plru(pkg_cache::U_LRU);
                end
            end
            EVICT: begin
                // The new line already hits here and supplies the read word
                set_mem_rdata_mux(pkg_cache::M_CACHE);
                set_pmem_addr_mux(pkg_cache::P_CACHE);
                pmem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/cache_datapath.sv
module cache_datapath #(
    parameter int S_INDEX = 3,
    localparam int TAG_W = pkg_cache::ADDR_W - S_INDEX - pkg_cache::OFFSET_W,
    localparam int NUM_SETS = 2 ** S_INDEX
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [pkg_cache::ADDR_W-1:0]  mem_address,
    input  logic [pkg_cache::WORD_W-1:0]  mem_wdata,
    output logic [pkg_cache::WORD_W-1:0]  mem_rdata,
    input  pkg_cache::cache_ctrl_t        ctrl,
    output pkg_cache::cache_stat_t        stat,
    input  logic [pkg_cache::LINE_W-1:0]  pmem_rdata,
    output logic [pkg_cache::LINE_W-1:0]  pmem_wdata,
    output logic [pkg_cache::ADDR_W-1:0]  pmem_address
);

    logic [S_INDEX-1:0]              index;
    logic [TAG_W-1:0]                cpu_tag;
    logic [pkg_cache::OFFSET_W-3:0]  word_sel;

    logic [1:0]             way_valid;
    logic [1:0]             way_dirty;
    logic [1:0]             way_hit;
    logic [TAG_W-1:0]       way_tag [2];
    pkg_cache::cache_line_u way_data [2];
    logic [1:0]             way_ld_valid;
    logic [1:0]             way_ld_dirty;
    logic [1:0]             way_ld_tag;
    logic [1:0]             way_ld_data;

    logic                hit;
    logic                hit_way;
    logic                lru_way;
    logic                dirty_way;
    logic                data_way;
    logic                plru_way;
    logic [NUM_SETS-1:0] plru;

    logic [TAG_W-1:0]       tmp_tag;
    pkg_cache::cache_line_u tmp_data;
    pkg_cache::cache_line_u fill_line;
    pkg_cache::cache_line_u line_in;

    assign index    = mem_address[pkg_cache::OFFSET_W +: S_INDEX];
    assign cpu_tag  = mem_address[pkg_cache::ADDR_W-1 -: TAG_W];
    assign word_sel = mem_address[pkg_cache::OFFSET_W-1:2];

    assign fill_line.line = pmem_rdata;

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way #(
            .S_INDEX(S_INDEX)
        ) u_way (
            .clk(clk),
            .rst(rst),
            .index(index),
            .ld_valid(way_ld_valid[w]),
            .ld_dirty(way_ld_dirty[w]),
            .ld_tag(way_ld_tag[w]),
            .ld_data(way_ld_data[w]),
            .dirty_in(ctrl.dirtyval),
            .tag_in(cpu_tag),
            .data_in(line_in),
            .valid(way_valid[w]),
            .dirty(way_dirty[w]),
            .tag(way_tag[w]),
            .data(way_data[w])
        );

        assign way_hit[w] = way_valid[w] && (way_tag[w] == cpu_tag);

        // Valid and tag always follow the line they describe
        assign way_ld_valid[w] = ctrl.ld_valid && (data_way == 1'(w));
        assign way_ld_tag[w]   = ctrl.ld_tag && (data_way == 1'(w));
        assign way_ld_data[w]  = ctrl.ld_data && (data_way == 1'(w));
        assign way_ld_dirty[w] = ctrl.ld_dirty && (dirty_way == 1'(w));
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign lru_way = plru[index];

    assign dirty_way = (ctrl.dirtywmux == pkg_cache::T_HIT) ? hit_way : lru_way;
    assign data_way  = (ctrl.datawmux == pkg_cache::W_HIT) ? hit_way : lru_way;
    assign plru_way  = (ctrl.plruwmux == pkg_cache::U_HIT) ? hit_way : lru_way;

    // On a miss the dirty bit describes the victim, on a hit the hit way
    assign stat.hit   = hit;
    assign stat.dirty = hit ? way_dirty[hit_way] : way_dirty[lru_way];

    always_ff @(posedge clk) begin
        if (rst)
            plru <= '0;
        else if (ctrl.ld_plru)
            plru[index] <= ~plru_way;
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_tmptag)
            tmp_tag <= way_tag[lru_way];
        if (ctrl.ld_tmpdata)
            tmp_data <= way_data[lru_way];
    end

    always_comb begin
        if (ctrl.datamux == pkg_cache::D_LLC)
            line_in = fill_line;
        else
            line_in = way_data[data_way];
        // Write-allocate merges the CPU word into the fill line as well
        if (mem_write)
            line_in.words[word_sel] = mem_wdata;
    end

    always_comb begin
        if (!mem_read)
            mem_rdata = '0;
        else if (ctrl.merdmux == pkg_cache::M_LLC)
            mem_rdata = fill_line.words[word_sel];
        else
            mem_rdata = way_data[hit_way].words[word_sel];
    end

    always_comb begin
        if (ctrl.pmadmux == pkg_cache::P_CACHE)
            pmem_address = {tmp_tag, index, {pkg_cache::OFFSET_W{1'b0}}};
        else
            pmem_address = {cpu_tag, index, {pkg_cache::OFFSET_W{1'b0}}};
    end

    assign pmem_wdata = tmp_data.line;

endmodule

//--- verilog/cache_way.sv
module cache_way #(
    parameter int S_INDEX = 3,
    localparam int TAG_W = pkg_cache::ADDR_W - S_INDEX - pkg_cache::OFFSET_W,
    localparam int NUM_SETS = 2 ** S_INDEX
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [S_INDEX-1:0]     index,
    input  logic                   ld_valid,
    input  logic                   ld_dirty,
    input  logic                   ld_tag,
    input  logic                   ld_data,
    input  logic                   dirty_in,
    input  logic [TAG_W-1:0]       tag_in,
    input  pkg_cache::cache_line_u data_in,
    output logic                   valid,
    output logic                   dirty,
    output logic [TAG_W-1:0]       tag,
    output pkg_cache::cache_line_u data
);

    logic [NUM_SETS-1:0]    valid_arr;
    logic [NUM_SETS-1:0]    dirty_arr;
    logic [TAG_W-1:0]       tag_arr [NUM_SETS];
    pkg_cache::cache_line_u data_arr [NUM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            // A line only ever becomes valid since there is no flush
            if (ld_valid)
                valid_arr[index] <= 1'b1;
            if (ld_dirty)
                dirty_arr[index] <= dirty_in;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_tag)
            tag_arr[index] <= tag_in;
        if (ld_data)
            data_arr[index] <= data_in;
    end

    assign valid = valid_arr[index];
    assign dirty = dirty_arr[index];
    assign tag   = tag_arr[index];
    assign data  = data_arr[index];

endmodule

//--- verilog/pkg_cache.sv
package pkg_cache;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 256;
    localparam int OFFSET_W = 5;

    // Way that a dirty bit write goes to
    typedef enum logic {
        T_HIT = 1'b0,
        T_LRU = 1'b1
    } dirtywmux_t;

    // Way that a line, tag or valid write goes to
    typedef enum logic {
        W_HIT = 1'b0,
        W_LRU = 1'b1
    } datawmux_t;

    // Way that is marked as most recently used
    typedef enum logic {
        U_HIT = 1'b0,
        U_LRU = 1'b1
    } plruwmux_t;

    typedef enum logic {
        D_CPU = 1'b0,
        D_LLC = 1'b1
    } datamux_t;

    typedef enum logic {
        M_CACHE = 1'b0,
        M_LLC   = 1'b1
    } merdmux_t;

    typedef enum logic {
        P_CPU   = 1'b0,
        P_CACHE = 1'b1
    } pmadmux_t;

    // Memory side moves the flat line, CPU side picks one word of it
    typedef union packed {
        logic [LINE_W-1:0]                    line;
        logic [LINE_W/WORD_W-1:0][WORD_W-1:0] words;
    } cache_line_u;

    typedef struct packed {
        logic       ld_valid;
        logic       ld_dirty;
        logic       ld_tag;
        logic       ld_data;
        logic       ld_tmptag;
        logic       ld_tmpdata;
        logic       ld_plru;
        logic       dirtyval;
        dirtywmux_t dirtywmux;
        datawmux_t  datawmux;
        plruwmux_t  plruwmux;
        datamux_t   datamux;
        merdmux_t   merdmux;
        pmadmux_t   pmadmux;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic dirty;
    } cache_stat_t;

endpackage
